/* include/csr_settings.svh */
// Data and address widths, CSR write masks, misa value and interrupt bit positions
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define CSR_XLEN 32
`define CSR_ADDR_W 12

// Write masks, one bit per field that software may change
`define CSR_MSTATUS_MASK 32'h0000_1888 // MPP, MPIE, MIE
`define CSR_MIE_MASK 32'h0000_0888 // MEIE, MTIE, MSIE
`define CSR_MTVEC_MASK 32'hFFFF_FFFC
`define CSR_MEPC_MASK 32'hFFFF_FFFC
`define CSR_FULL_MASK 32'hFFFF_FFFF

// MXL = 1, extensions U, M, I
`define CSR_MISA_VALUE 32'h4010_1100

// Interrupt line positions in mip and mie
`define CSR_IRQ_EXT_BIT 11
`define CSR_IRQ_SW_BIT 3
`define CSR_IRQ_TIM_BIT 7

`endif

/* verilog/csr_pkg.sv */
// Package with CSR operation, address, exception, interrupt, privilege and trap enums
`default_nettype none

`include "csr_settings.svh"

package csr_pkg;

    typedef enum logic [1:0] {WRITE, SET, CLEAR} csr_op_e;

    typedef enum logic [`CSR_ADDR_W-1:0] {
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        MCYCLE     = 12'hB00,
        MINSTRET   = 12'hB02,
        MCYCLEH    = 12'hB80,
        MINSTRETH  = 12'hB82,
        CYCLE      = 12'hC00, // User aliases, read only
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        INSTRETH   = 12'hC82,
        MVENDORID  = 12'hF11, // ID block reads zero
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15
    } csr_addr_e;

    typedef enum logic [4:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 5'd0,
        INSTRUCTION_ACCESS_FAULT       = 5'd1,
        ILLEGAL_INSTRUCTION            = 5'd2,
        BREAKPOINT                     = 5'd3,
        LOAD_ADDRESS_MISALIGNED        = 5'd4,
        LOAD_ACCESS_FAULT              = 5'd5,
        STORE_AMO_ADDRESS_MISALIGNED   = 5'd6,
        STORE_AMO_ACCESS_FAULT         = 5'd7,
        ECALL_FROM_UMODE               = 5'd8,
        ECALL_FROM_SMODE               = 5'd9,
        ECALL_FROM_MMODE               = 5'd11,
        INSTRUCTION_PAGE_FAULT         = 5'd12,
        LOAD_PAGE_FAULT                = 5'd13,
        STORE_AMO_PAGE_FAULT           = 5'd15
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    typedef enum logic [1:0] {USER = 2'b00, MACHINE = 2'b11} priv_e;

    typedef enum logic [1:0] {
        TRAP_NONE, TRAP_RETURN, TRAP_EXCEPTION, TRAP_INTERRUPT
    } trap_kind_e;

endpackage

`default_nettype wire

/* verilog/csr_state_if.sv */
// Interface carrying the architectural CSR values from the register state to its readers
`default_nettype none

`include "csr_settings.svh"

interface csr_state_if;

    logic [`CSR_XLEN-1:0]   mstatus;
    logic [`CSR_XLEN-1:0]   mie;
    logic [`CSR_XLEN-1:0]   mip;
    logic [`CSR_XLEN-1:0]   mtvec;
    logic [`CSR_XLEN-1:0]   mscratch;
    logic [`CSR_XLEN-1:0]   mepc;
    logic [`CSR_XLEN-1:0]   mcause;
    logic [`CSR_XLEN-1:0]   mtval;
    logic [2*`CSR_XLEN-1:0] mcycle;   // 64-bit counters
    logic [2*`CSR_XLEN-1:0] minstret;
    csr_pkg::priv_e         priv;

    modport state (output mstatus, mie, mip, mtvec, mscratch, mepc, mcause, mtval,
                   mcycle, minstret, priv);
    modport reader (input mstatus, mie, mip, mtvec, mscratch, mepc, mcause, mtval,
                    mcycle, minstret, priv);

endinterface

`default_nettype wire

/* verilog/csr_access_unit.sv */
// CSR access unit: address decode, write masks, read-modify-write and read multiplexer
`default_nettype none

`include "csr_settings.svh"

module csr_access_unit (
    input  wire logic [`CSR_ADDR_W-1:0] address_i,
    input  wire csr_pkg::csr_op_e       op_i,
    input  wire logic [`CSR_XLEN-1:0]   data_i,
    input  wire logic                   read_enable_i,
    input  wire logic                   write_enable_i,
    input  wire logic                   killed_i,
    csr_state_if.reader                 st,
    output logic                        wr_req_o,
    output csr_pkg::csr_addr_e          wr_addr_o,
    output logic [`CSR_XLEN-1:0]        wr_data_o,
    output logic [`CSR_XLEN-1:0]        read_data_o
);

    csr_pkg::csr_addr_e   addr;
    logic [`CSR_XLEN-1:0] cur_val;
    logic [`CSR_XLEN-1:0] wmask;

    assign addr = csr_pkg::csr_addr_e'(address_i);

    ////////////////////////////////////////////////////////////
    // Current value and write mask per address
    ////////////////////////////////////////////////////////////
    always_comb begin
        wmask = '0; // Read only unless listed
        case (addr)
            csr_pkg::MSTATUS:   begin cur_val = st.mstatus;        wmask = `CSR_MSTATUS_MASK; end
            csr_pkg::MISA:      cur_val = `CSR_MISA_VALUE;         // Constant
            csr_pkg::MIE:       begin cur_val = st.mie;            wmask = `CSR_MIE_MASK; end
            csr_pkg::MTVEC:     begin cur_val = st.mtvec;          wmask = `CSR_MTVEC_MASK; end
            csr_pkg::MSCRATCH:  begin cur_val = st.mscratch;       wmask = `CSR_FULL_MASK; end
            csr_pkg::MEPC:      begin cur_val = st.mepc;           wmask = `CSR_MEPC_MASK; end
            csr_pkg::MCAUSE:    begin cur_val = st.mcause;         wmask = `CSR_FULL_MASK; end
            csr_pkg::MTVAL:     begin cur_val = st.mtval;          wmask = `CSR_FULL_MASK; end
            csr_pkg::MIP:       cur_val = st.mip;                  // Follows the irq lines
            csr_pkg::MCYCLE:    begin cur_val = st.mcycle[31:0];   wmask = `CSR_FULL_MASK; end
            csr_pkg::MCYCLEH:   begin cur_val = st.mcycle[63:32];  wmask = `CSR_FULL_MASK; end
            csr_pkg::MINSTRET:  begin cur_val = st.minstret[31:0]; wmask = `CSR_FULL_MASK; end
            csr_pkg::MINSTRETH: begin cur_val = st.minstret[63:32]; wmask = `CSR_FULL_MASK; end
            csr_pkg::CYCLE:     cur_val = st.mcycle[31:0];
            csr_pkg::CYCLEH:    cur_val = st.mcycle[63:32];
            csr_pkg::INSTRET:   cur_val = st.minstret[31:0];
            csr_pkg::INSTRETH:  cur_val = st.minstret[63:32];
            csr_pkg::MVENDORID, csr_pkg::MARCHID, csr_pkg::MIMPID,
            csr_pkg::MHARTID, csr_pkg::MCONFIGPTR:
                                cur_val = '0;
            default:            cur_val = '0;              // Unknown address
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Write, set and clear
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (op_i)
            csr_pkg::SET:   wr_data_o = (cur_val | data_i) & wmask;
            csr_pkg::CLEAR: wr_data_o = (cur_val & ~data_i) & wmask;
            default:        wr_data_o = data_i & wmask;
        endcase
    end

    assign wr_req_o    = write_enable_i & ~killed_i;
    assign wr_addr_o   = addr;
    assign read_data_o = (read_enable_i && !killed_i) ? cur_val : '0;

endmodule

`default_nettype wire

/* verilog/trap_unit.sv */
// Trap unit: selects return, exception or interrupt and forms cause, return address and mtval
`default_nettype none

`include "csr_settings.svh"

module trap_unit (
    input  wire logic                 machine_return_i,
    input  wire logic                 raise_exception_i,
    input  wire logic                 interrupt_ack_i,
    input  wire csr_pkg::exc_code_e   exception_code_i,
    input  wire csr_pkg::irq_code_e   irq_code_i,
    input  wire logic [`CSR_XLEN-1:0] pc_i,
    input  wire logic [`CSR_XLEN-1:0] instruction_i,
    input  wire logic [`CSR_XLEN-1:0] jump_target_i,
    input  wire logic                 jump_i,
    output csr_pkg::trap_kind_e       trap_kind_o,
    output logic [`CSR_XLEN-1:0]      trap_cause_o,
    output logic [`CSR_XLEN-1:0]      trap_epc_o,
    output logic [`CSR_XLEN-1:0]      trap_tval_o
);

    always_comb begin
        trap_kind_o  = csr_pkg::TRAP_NONE;
        trap_cause_o = '0;
        trap_epc_o   = '0;
        trap_tval_o  = '0;
        if (machine_return_i) begin
            trap_kind_o = csr_pkg::TRAP_RETURN;
        end else if (raise_exception_i) begin
            trap_kind_o  = csr_pkg::TRAP_EXCEPTION;
            trap_cause_o = {1'b0, 26'b0, exception_code_i};
            // ECALL and EBREAK come back to the trapping instruction
            if (exception_code_i == csr_pkg::ECALL_FROM_MMODE ||
                exception_code_i == csr_pkg::BREAKPOINT) begin
                trap_epc_o = pc_i;
            end else begin
                trap_epc_o = pc_i + 32'd4;
            end
            trap_tval_o = (exception_code_i == csr_pkg::ILLEGAL_INSTRUCTION) ? instruction_i : pc_i;
        end else if (interrupt_ack_i) begin
            trap_kind_o  = csr_pkg::TRAP_INTERRUPT;
            trap_cause_o = {1'b1, 26'b0, irq_code_i}; // Interrupt bit set
            trap_epc_o   = jump_i ? jump_target_i : pc_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/irq_unit.sv */
// Interrupt unit: samples irq lines into mip, flags pending interrupts, picks the code
`default_nettype none

`include "csr_settings.svh"

module irq_unit (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic [`CSR_XLEN-1:0] irq_i,
    input  wire logic                 interrupt_ack_i,
    csr_state_if.reader               st,
    output logic [`CSR_XLEN-1:0]      mip_o,
    output csr_pkg::irq_code_e        irq_code_o,
    output logic                      interrupt_pending_o
);

    logic [`CSR_XLEN-1:0] enabled;

    assign enabled = st.mie & mip_o;

    // Stage 1, line sampling
    always_ff @(posedge clk) begin
        if (reset) begin
            mip_o <= '0;
        end else begin
            mip_o <= irq_i;
        end
    end

    // Stage 2, pending flag and code
    always_ff @(posedge clk) begin
        if (reset) begin
            interrupt_pending_o <= 1'b0;
        end else if (st.mstatus[3] && enabled != '0 && !interrupt_ack_i) begin
            interrupt_pending_o <= 1'b1;
            if (enabled[`CSR_IRQ_EXT_BIT])      irq_code_o <= csr_pkg::M_EXT_INT;
            else if (enabled[`CSR_IRQ_SW_BIT])  irq_code_o <= csr_pkg::M_SW_INT;
            else if (enabled[`CSR_IRQ_TIM_BIT]) irq_code_o <= csr_pkg::M_TIM_INT;
        end else begin
            interrupt_pending_o <= 1'b0; // Dropped on ack or when disabled
        end
    end

endmodule

`default_nettype wire

/* verilog/csr_state.sv */
// Register state: CSRs, mstatus fields, privilege, counters and trap versus write arbitration
`default_nettype none

`include "csr_settings.svh"

module csr_state (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 killed_i,
    input  wire csr_pkg::trap_kind_e  trap_kind_i,
    input  wire logic [`CSR_XLEN-1:0] trap_cause_i,
    input  wire logic [`CSR_XLEN-1:0] trap_epc_i,
    input  wire logic [`CSR_XLEN-1:0] trap_tval_i,
    input  wire logic                 wr_req_i,
    input  wire csr_pkg::csr_addr_e   wr_addr_i,
    input  wire logic [`CSR_XLEN-1:0] wr_data_i,
    input  wire logic [`CSR_XLEN-1:0] mip_i,
    csr_state_if.state                st
);

    logic                   mstatus_mie;
    logic                   mstatus_mpie;
    csr_pkg::priv_e         mstatus_mpp;
    csr_pkg::priv_e         priv;
    logic [`CSR_XLEN-1:0]   mie, mtvec, mscratch, mepc, mcause, mtval;
    logic [2*`CSR_XLEN-1:0] mcycle, minstret;

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= csr_pkg::USER;
            priv         <= csr_pkg::MACHINE;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
            mcycle       <= '0;
            minstret     <= '0;
        end else begin
            mcycle <= mcycle + 64'd1; // Free running, a CSR write below takes over
            if (!killed_i) minstret <= minstret + 64'd1;

            ////////////////////////////////////////////////////////////
            // Trap first, CSR write only when no trap
            ////////////////////////////////////////////////////////////
            case (trap_kind_i)
                csr_pkg::TRAP_RETURN: begin
                    mstatus_mie <= mstatus_mpie;
                    priv        <= mstatus_mpp;
                end
                csr_pkg::TRAP_EXCEPTION, csr_pkg::TRAP_INTERRUPT: begin
                    mstatus_mpie <= mstatus_mie;
                    mstatus_mie  <= 1'b0;
                    mstatus_mpp  <= priv;
                    priv         <= csr_pkg::MACHINE;
                    mcause       <= trap_cause_i;
                    mepc         <= trap_epc_i;
                    if (trap_kind_i == csr_pkg::TRAP_EXCEPTION) mtval <= trap_tval_i;
                end
                default: begin
                    if (wr_req_i) begin
                        case (wr_addr_i)
                            csr_pkg::MSTATUS: begin
                                mstatus_mie  <= wr_data_i[3];
                                mstatus_mpie <= wr_data_i[7];
                                // Only U and M exist
                                mstatus_mpp  <= (wr_data_i[12:11] == 2'b00) ? csr_pkg::USER
                                                                          : csr_pkg::MACHINE;
                            end
                            csr_pkg::MIE:       mie             <= wr_data_i;
                            csr_pkg::MTVEC:     mtvec           <= wr_data_i;
                            csr_pkg::MSCRATCH:  mscratch        <= wr_data_i;
                            csr_pkg::MEPC:      mepc            <= wr_data_i;
                            csr_pkg::MCAUSE:    mcause          <= wr_data_i;
                            csr_pkg::MTVAL:     mtval           <= wr_data_i;
                            csr_pkg::MCYCLE:    mcycle[31:0]    <= wr_data_i;
                            csr_pkg::MCYCLEH:   mcycle[63:32]   <= wr_data_i;
                            csr_pkg::MINSTRET:  minstret[31:0]  <= wr_data_i;
                            csr_pkg::MINSTRETH: minstret[63:32] <= wr_data_i;
                            default: ; // Read only or unknown
                        endcase
                    end
                end
            endcase
        end
    end

    // MPP 12:11, MPIE 7, MIE 3, all other fields zero
    assign st.mstatus  = {19'b0, mstatus_mpp, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
    assign st.mie      = mie;
    assign st.mip      = mip_i;
    assign st.mtvec    = mtvec;
    assign st.mscratch = mscratch;
    assign st.mepc     = mepc;
    assign st.mcause   = mcause;
    assign st.mtval    = mtval;
    assign st.mcycle   = mcycle;
    assign st.minstret = minstret;
    assign st.priv     = priv;

endmodule

`default_nettype wire

/* verilog/csr_top.sv */
// CSR bank top level wiring access unit, trap unit, interrupt unit and register state
`default_nettype none

`include "csr_settings.svh"

module csr_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   read_enable_i,
    input  wire logic                   write_enable_i,
    input  wire csr_pkg::csr_op_e       op_i,
    input  wire logic [`CSR_ADDR_W-1:0] address_i,
    input  wire logic [`CSR_XLEN-1:0]   data_i,
    input  wire logic                   killed_i,
    output logic [`CSR_XLEN-1:0]        read_data_o,
    input  wire logic                   raise_exception_i,
    input  wire logic                   machine_return_i,
    input  wire csr_pkg::exc_code_e     exception_code_i,
    input  wire logic [`CSR_XLEN-1:0]   pc_i,
    input  wire logic [`CSR_XLEN-1:0]   instruction_i,
    input  wire logic                   jump_i,
    input  wire logic [`CSR_XLEN-1:0]   jump_target_i,
    input  wire logic [`CSR_XLEN-1:0]   irq_i,
    input  wire logic                   interrupt_ack_i,
    output logic                        interrupt_pending_o,
    output csr_pkg::priv_e              priv_o,
    output logic [`CSR_XLEN-1:0]        mepc_o,
    output logic [`CSR_XLEN-1:0]        mtvec_o
);

    logic                 wr_req;
    csr_pkg::csr_addr_e   wr_addr;
    logic [`CSR_XLEN-1:0] wr_data;
    csr_pkg::trap_kind_e  trap_kind;
    logic [`CSR_XLEN-1:0] trap_cause, trap_epc, trap_tval;
    logic [`CSR_XLEN-1:0] mip;
    csr_pkg::irq_code_e   irq_code;

    csr_state_if st_if ();

    csr_access_unit u_access (
        .address_i, .op_i, .data_i, .read_enable_i, .write_enable_i, .killed_i,
        .st(st_if.reader), .wr_req_o(wr_req), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
        .read_data_o
    );

    trap_unit u_trap (
        .machine_return_i, .raise_exception_i, .interrupt_ack_i, .exception_code_i,
        .irq_code_i(irq_code), .pc_i, .instruction_i, .jump_target_i, .jump_i,
        .trap_kind_o(trap_kind), .trap_cause_o(trap_cause), .trap_epc_o(trap_epc),
        .trap_tval_o(trap_tval)
    );

    irq_unit u_irq (
        .clk, .reset, .irq_i, .interrupt_ack_i, .st(st_if.reader), .mip_o(mip),
        .irq_code_o(irq_code), .interrupt_pending_o
    );

    // Shared register state, trap has priority over CSR writes
    csr_state u_state (
        .clk, .reset, .killed_i, .trap_kind_i(trap_kind), .trap_cause_i(trap_cause),
        .trap_epc_i(trap_epc), .trap_tval_i(trap_tval), .wr_req_i(wr_req),
        .wr_addr_i(wr_addr), .wr_data_i(wr_data), .mip_i(mip), .st(st_if.state)
    );

    assign priv_o  = st_if.priv;
    assign mepc_o  = st_if.mepc;
    assign mtvec_o = st_if.mtvec;

endmodule

`default_nettype wire

/* bench/csr_asserts.sv */
// Concurrent assertions on interrupt acknowledge, trap privilege and killed reads
`default_nettype none

`include "csr_settings.svh"

module csr_asserts (
    input wire logic                 clk,
    input wire logic                 reset,
    input wire logic                 killed_i,
    input wire logic [`CSR_XLEN-1:0] read_data_i,
    input wire logic                 raise_exception_i,
    input wire logic                 machine_return_i,
    input wire logic                 interrupt_ack_i,
    input wire logic                 pending_i,
    input wire csr_pkg::priv_e       priv_i
);
    timeunit 1ns;
    timeprecision 1ps;

    ack_drops_pending: assert property (@(posedge clk) disable iff (reset)
        interrupt_ack_i |=> !pending_i)
        else $error("interrupt_pending_o still high the cycle after interrupt_ack_i");

    // Return has priority over exception and interrupt
    trap_enters_machine: assert property (@(posedge clk) disable iff (reset)
        (raise_exception_i || interrupt_ack_i) && !machine_return_i
            |=> priv_i == csr_pkg::MACHINE)
        else $error("priv_o not MACHINE after a trap");

    killed_reads_zero: assert property (@(posedge clk) disable iff (reset)
        killed_i |-> read_data_i == '0)
        else $error("read_data_o nonzero while killed_i is high");

endmodule

bind csr_top csr_asserts u_asserts (
    .clk(clk), .reset(reset), .killed_i(killed_i), .read_data_i(read_data_o),
    .raise_exception_i(raise_exception_i), .machine_return_i(machine_return_i),
    .interrupt_ack_i(interrupt_ack_i), .pending_i(interrupt_pending_o), .priv_i(priv_o)
);

`default_nettype wire

/* bench/csr_tb.sv */
// Testbench for the CSR bank with clock, reset, stimulus, reference model and compare process
`default_nettype none

`include "csr_settings.svh"

module csr_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk;
    logic                   reset;
    logic                   read_enable_i;
    logic                   write_enable_i;
    csr_pkg::csr_op_e       op_i;
    logic [`CSR_ADDR_W-1:0] address_i;
    logic [`CSR_XLEN-1:0]   data_i;
    logic                   killed_i;
    logic [`CSR_XLEN-1:0]   read_data_o;
    logic                   raise_exception_i;
    logic                   machine_return_i;
    csr_pkg::exc_code_e     exception_code_i;
    logic [`CSR_XLEN-1:0]   pc_i;
    logic [`CSR_XLEN-1:0]   instruction_i;
    logic                   jump_i;
    logic [`CSR_XLEN-1:0]   jump_target_i;
    logic [`CSR_XLEN-1:0]   irq_i;
    logic                   interrupt_ack_i;
    logic                   interrupt_pending_o;
    csr_pkg::priv_e         priv_o;
    logic [`CSR_XLEN-1:0]   mepc_o;
    logic [`CSR_XLEN-1:0]   mtvec_o;

    integer      seed;
    int          checks;
    int          errors;
    int          timeouts;
    logic [31:0] got_q[$]; // Pending comparisons
    logic [31:0] exp_q[$];
    string       tag_q[$];

    csr_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Bits outside the mask keep their old value
    function automatic logic [31:0] expect_write(input csr_pkg::csr_op_e op,
            input logic [31:0] old, input logic [31:0] data, input logic [31:0] mask);
        logic [31:0] updated;
        case (op)
            csr_pkg::SET:   updated = old | data;
            csr_pkg::CLEAR: updated = old & ~data;
            default:        updated = data;
        endcase
        return (old & ~mask) | (updated & mask);
    endfunction

    // Nonzero MPP becomes M since only U and M exist
    function automatic logic [31:0] legal_mstatus(input logic [31:0] value);
        logic [31:0] fixed;
        fixed = value;
        if (value[12:11] != 2'b00) begin
            fixed[12:11] = 2'b11;
        end
        return fixed;
    endfunction

    function automatic logic [31:0] irq_cause(input logic [31:0] lines);
        if (lines[`CSR_IRQ_EXT_BIT]) begin
            return 32'h8000_0000 | `CSR_IRQ_EXT_BIT; // External first
        end else if (lines[`CSR_IRQ_SW_BIT]) begin
            return 32'h8000_0000 | `CSR_IRQ_SW_BIT;
        end else if (lines[`CSR_IRQ_TIM_BIT]) begin
            return 32'h8000_0000 | `CSR_IRQ_TIM_BIT;
        end
        return 32'h0;
    endfunction

    task automatic queue_check(input string tag, input logic [31:0] got,
                               input logic [31:0] exp);
        got_q.push_back(got);
        exp_q.push_back(exp);
        tag_q.push_back(tag);
    endtask

    // Drains the pending comparisons on every rising edge
    always @(posedge clk) begin : compare
        logic [31:0] got;
        logic [31:0] exp;
        string       tag;
        while (got_q.size() > 0) begin
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            tag = tag_q.pop_front();
            checks++;
            assert (got == exp) else begin
                $display("FAIL %0t: %s read %h, expected %h", $time, tag, got, exp);
                errors++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Bus tasks driven on the falling edge
    ////////////////////////////////////////////////////////////
    task automatic write_csr(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                             input logic [31:0] data, input logic kill);
        @(negedge clk);
        write_enable_i = 1'b1;
        op_i = op;
        address_i = addr;
        data_i = data;
        killed_i = kill;
        @(negedge clk);
        write_enable_i = 1'b0;
        killed_i = 1'b0;
    endtask

    task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
        @(negedge clk);
        read_enable_i = 1'b1;
        address_i = addr;
        killed_i = 1'b0;
        #10;
        data = read_data_o; // Combinational read has settled
        read_enable_i = 1'b0;
    endtask

    task automatic check_read(input string tag, input logic [11:0] addr,
                              input logic [31:0] exp);
        logic [31:0] value;
        read_csr(addr, value);
        queue_check(tag, value, exp);
    endtask

    task automatic pulse_exception(input csr_pkg::exc_code_e code, input logic [31:0] pc,
                                   input logic [31:0] instr);
        @(negedge clk);
        raise_exception_i = 1'b1;
        exception_code_i = code;
        pc_i = pc;
        instruction_i = instr;
        @(negedge clk);
        raise_exception_i = 1'b0;
    endtask

    task automatic pulse_mret();
        @(negedge clk);
        machine_return_i = 1'b1;
        @(negedge clk);
        machine_return_i = 1'b0;
    endtask

    initial begin : stimulus
        logic [31:0]        rnd;
        logic [31:0]        value;
        logic [31:0]        first;
        logic [31:0]        pc;
        logic [31:0]        exp_epc;
        logic [11:0]        reg_addr [0:4];
        logic [31:0]        reg_mask [0:4];
        logic [31:0]        model [0:4];
        logic [31:0]        irq_pat [0:3];
        csr_pkg::exc_code_e codes [0:3];
        csr_pkg::csr_op_e   op;
        int                 idx;
        int                 waited;
        int                 retired;

        seed = 94374;
        checks = 0;
        errors = 0;
        timeouts = 0;
        reset = 1'b1;
        read_enable_i = 1'b0;
        write_enable_i = 1'b0;
        op_i = csr_pkg::WRITE;
        address_i = '0;
        data_i = '0;
        killed_i = 1'b0;
        raise_exception_i = 1'b0;
        machine_return_i = 1'b0;
        exception_code_i = csr_pkg::ILLEGAL_INSTRUCTION;
        pc_i = '0;
        instruction_i = '0;
        jump_i = 1'b0;
        jump_target_i = '0;
        irq_i = '0;
        interrupt_ack_i = 1'b0;

        reg_addr[0] = csr_pkg::MSCRATCH;
        reg_addr[1] = csr_pkg::MTVEC;
        reg_addr[2] = csr_pkg::MEPC;
        reg_addr[3] = csr_pkg::MIE;
        reg_addr[4] = csr_pkg::MSTATUS;
        reg_mask[0] = `CSR_FULL_MASK;
        reg_mask[1] = `CSR_MTVEC_MASK;
        reg_mask[2] = `CSR_MEPC_MASK;
        reg_mask[3] = `CSR_MIE_MASK;
        reg_mask[4] = `CSR_MSTATUS_MASK;
        for (int k = 0; k < 5; k++) begin
            model[k] = '0;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        queue_check("priv after reset", {30'b0, priv_o}, {30'b0, csr_pkg::MACHINE});
        queue_check("pending after reset", {31'b0, interrupt_pending_o}, 32'h0);
        check_read("mscratch after reset", csr_pkg::MSCRATCH, 32'h0);
        check_read("mcause after reset", csr_pkg::MCAUSE, 32'h0);

        // Random masked accesses against the model
        for (int k = 0; k < 60; k++) begin
            rnd = $random(seed);
            idx = rnd % 5;
            rnd = $random(seed);
            rnd = rnd % 3;
            op = csr_pkg::csr_op_e'(rnd[1:0]);
            value = $random(seed);
            write_csr(op, reg_addr[idx], value, 1'b0);
            model[idx] = expect_write(op, model[idx], value, reg_mask[idx]);
            if (reg_addr[idx] == csr_pkg::MSTATUS) begin
                model[idx] = legal_mstatus(model[idx]);
            end
            check_read($sformatf("csr %h", reg_addr[idx]), reg_addr[idx], model[idx]);
            if (reg_addr[idx] == csr_pkg::MTVEC) begin
                queue_check("mtvec_o", mtvec_o, model[idx]);
            end
        end

        // Killed write, killed read, unknown and ID addresses, misa
        rnd = $random(seed);
        write_csr(csr_pkg::WRITE, csr_pkg::MSCRATCH, rnd, 1'b1);
        check_read("killed write", csr_pkg::MSCRATCH, model[0]);
        @(negedge clk);
        read_enable_i = 1'b1;
        address_i = csr_pkg::MISA;
        killed_i = 1'b1;
        #10;
        queue_check("killed read", read_data_o, 32'h0);
        read_enable_i = 1'b0;
        killed_i = 1'b0;
        check_read("unknown address", 12'h7C0, 32'h0);
        check_read("mvendorid", csr_pkg::MVENDORID, 32'h0);
        check_read("mhartid", csr_pkg::MHARTID, 32'h0);
        check_read("misa", csr_pkg::MISA, `CSR_MISA_VALUE);

        ////////////////////////////////////////////////////////////
        // Exceptions and machine return
        ////////////////////////////////////////////////////////////
        codes[0] = csr_pkg::ILLEGAL_INSTRUCTION;
        codes[1] = csr_pkg::BREAKPOINT;
        codes[2] = csr_pkg::ECALL_FROM_MMODE;
        codes[3] = csr_pkg::LOAD_ACCESS_FAULT;
        for (int k = 0; k < 4; k++) begin
            pc = $random(seed);
            pc[1:0] = 2'b00;
            rnd = $random(seed);
            pulse_exception(codes[k], pc, rnd);
            if (codes[k] == csr_pkg::ECALL_FROM_MMODE || codes[k] == csr_pkg::BREAKPOINT) begin
                exp_epc = pc;
            end else begin
                exp_epc = pc + 32'd4;
            end
            check_read("mepc after exception", csr_pkg::MEPC, exp_epc);
            queue_check("mepc_o after exception", mepc_o, exp_epc);
            check_read("mtval after exception", csr_pkg::MTVAL,
                       (codes[k] == csr_pkg::ILLEGAL_INSTRUCTION) ? rnd : pc);
            check_read("mcause after exception", csr_pkg::MCAUSE, {27'b0, codes[k]});
            queue_check("priv after exception", {30'b0, priv_o}, {30'b0, csr_pkg::MACHINE});
        end

        write_csr(csr_pkg::WRITE, csr_pkg::MSTATUS, 32'h0000_0088, 1'b0); // MIE, MPIE, MPP=U
        pulse_mret();
        queue_check("priv after mret", {30'b0, priv_o}, {30'b0, csr_pkg::USER});
        pulse_exception(csr_pkg::ILLEGAL_INSTRUCTION, 32'h0000_1000, 32'h0);
        check_read("mstatus after trap", csr_pkg::MSTATUS, 32'h0000_0080); // MIE now in MPIE
        queue_check("priv after trap", {30'b0, priv_o}, {30'b0, csr_pkg::MACHINE});
        pulse_mret();
        check_read("mstatus after mret", csr_pkg::MSTATUS, 32'h0000_0088);
        queue_check("priv restored", {30'b0, priv_o}, {30'b0, csr_pkg::USER});

        ////////////////////////////////////////////////////////////
        // Interrupts
        ////////////////////////////////////////////////////////////
        write_csr(csr_pkg::WRITE, csr_pkg::MIE, `CSR_MIE_MASK, 1'b0);
        write_csr(csr_pkg::WRITE, csr_pkg::MSTATUS, 32'h0000_0088, 1'b0);
        irq_pat[0] = (32'd1 << `CSR_IRQ_SW_BIT) | (32'd1 << `CSR_IRQ_TIM_BIT);
        irq_pat[1] = (32'd1 << `CSR_IRQ_EXT_BIT) | (32'd1 << `CSR_IRQ_SW_BIT);
        irq_pat[2] = 32'd1 << `CSR_IRQ_TIM_BIT;
        irq_pat[3] = (32'd1 << `CSR_IRQ_EXT_BIT) | (32'd1 << `CSR_IRQ_TIM_BIT);
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            irq_i = irq_pat[k];
            waited = 0;
            while (!interrupt_pending_o && waited < 20) begin
                @(negedge clk);
                waited++;
            end
            assert (interrupt_pending_o) else begin
                $display("Timed out waiting for interrupt_pending_o with irq lines %h",
                         irq_pat[k]);
                timeouts++;
            end
            if (interrupt_pending_o) begin
                queue_check("interrupt latency", waited, 32'd2);
                pc = $random(seed);
                rnd = $random(seed);
                interrupt_ack_i = 1'b1;
                pc_i = pc;
                jump_i = k[0]; // Every other one taken during a jump
                jump_target_i = rnd;
                irq_i = '0;
                @(negedge clk);
                interrupt_ack_i = 1'b0;
                jump_i = 1'b0;
                queue_check("pending after ack", {31'b0, interrupt_pending_o}, 32'h0);
                check_read("mcause after interrupt", csr_pkg::MCAUSE, irq_cause(irq_pat[k]));
                check_read("mepc after interrupt", csr_pkg::MEPC, k[0] ? rnd : pc);
                pulse_mret();
            end else begin
                irq_i = '0;
            end
        end

        // Counters
        read_csr(csr_pkg::MCYCLE, first);
        repeat (6) @(negedge clk);
        read_csr(csr_pkg::MCYCLE, value);
        queue_check("mcycle delta", value - first, 32'd7);

        read_csr(csr_pkg::MINSTRET, first);
        retired = 1; // Read cycle itself is not killed
        repeat (9) begin
            @(negedge clk);
            rnd = $random(seed);
            killed_i = rnd[0];
            if (!rnd[0]) begin
                retired++;
            end
        end
        read_csr(csr_pkg::MINSTRET, value);
        queue_check("minstret delta", value - first, retired);

        @(negedge clk);
        @(negedge clk);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
verilog/csr_pkg.sv
verilog/csr_state_if.sv
verilog/csr_access_unit.sv
verilog/trap_unit.sv
verilog/irq_unit.sv
verilog/csr_state.sv
verilog/csr_top.sv
bench/csr_asserts.sv
bench/csr_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the CSR bank testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module csr_tb \
    -f src.f -o csr_sim > build.log 2>&1 &&
    ./obj_dir/csr_sim > sim.log 2>&1 ||
    { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "TESTS PASSED" sim.log && echo "Simulation passed" ||
    { echo "Simulation failed, see sim.log"; exit 1; }
